// ==== Bender.yml ====
package:
  name: rename_map

sources:
  - rename_pkg.sv
  - regfile.sv
  - bundle_dep_check.sv
  - rename_top.sv
  - target: simulation
    files:
      - rename_assertions.sv
      - tb_rename.sv

// ==== bundle_dep_check.sv ====
`timescale 1ns/1ps

module bundle_dep_check (
  input  rename_pkg::rename_req_t [rename_pkg::LANES-1:0] req,
  input  rename_pkg::ptag_t       [rename_pkg::LANES-1:0] map_a,  // src_a lookups
  input  rename_pkg::ptag_t       [rename_pkg::LANES-1:0] map_b,  // src_b lookups
  input  rename_pkg::ptag_t       [rename_pkg::LANES-1:0] map_c,  // dest lookups
  output rename_pkg::rename_rsp_t [rename_pkg::LANES-1:0] rsp
);

  //////////////////////////////
  // lane 0 producer
  //////////////////////////////

  logic              lane0_wr;                            // lane 0 renames a dest
  rename_pkg::ptag_t lane0_tag;                           // tag it hands out

  // the zero reg never takes a new tag, so it never bypasses either
  assign lane0_wr  = req[0].valid && req[0].dest_valid &&
                     (req[0].dest != rename_pkg::ZERO_REG);
  assign lane0_tag = req[0].new_tag;

  // lane 1 idx hits lane 0 dest -> lane 0's new tag, else table lookup
  function automatic rename_pkg::ptag_t bypass(
    input rename_pkg::arch_idx_t idx,
    input rename_pkg::arch_idx_t prod_dest,
    input logic                  prod_wr,
    input rename_pkg::ptag_t     prod_tag,
    input rename_pkg::ptag_t     lookup
  );
    rename_pkg::ptag_t tag;
    tag = lookup;
    if (prod_wr && (idx == prod_dest)) begin
      tag = prod_tag;                                     // younger sees older's rename
    end
    return tag;
  endfunction

  //////////////////////////////
  // per-lane results
  //////////////////////////////

  always_comb begin
    // lane 0 is oldest, the table is already correct for it
    rsp[0].tag_a   = map_a[0];
    rsp[0].tag_b   = map_b[0];
    rsp[0].old_tag = map_c[0];

    // lane 1 renames after lane 0 in program order
    rsp[1].tag_a   = bypass(req[1].src_a, req[0].dest, lane0_wr, lane0_tag, map_a[1]);
    rsp[1].tag_b   = bypass(req[1].src_b, req[0].dest, lane0_wr, lane0_tag, map_b[1]);
    rsp[1].old_tag = bypass(req[1].dest,  req[0].dest, lane0_wr, lane0_tag, map_c[1]);
    // old_tag bypass: same dest twice, lane 1 frees lane 0's tag
  end

endmodule

// ==== files.f ====
rename_pkg.sv
regfile.sv
bundle_dep_check.sv
rename_top.sv
rename_assertions.sv
tb_rename.sv

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile #(
  parameter int IDX_WIDTH = rename_pkg::ARCH_IDX_WIDTH,
  parameter int DATA_WIDTH = rename_pkg::TAG_WIDTH,
  parameter logic [IDX_WIDTH-1:0] ZERO_REGISTER = rename_pkg::ZERO_REG,
  parameter logic [DATA_WIDTH-1:0] ZERO_REG_VAL = rename_pkg::ZERO_TAG
) (
  input  logic                                          wr_clk,
  input  logic                                          reset,        // sync, to identity

  // read ports, one per lane each
  input  rename_pkg::arch_idx_t [rename_pkg::LANES-1:0] rda_idx,
  input  rename_pkg::arch_idx_t [rename_pkg::LANES-1:0] rdb_idx,
  input  rename_pkg::arch_idx_t [rename_pkg::LANES-1:0] rdc_idx,
  output rename_pkg::ptag_t     [rename_pkg::LANES-1:0] rda_out,
  output rename_pkg::ptag_t     [rename_pkg::LANES-1:0] rdb_out,
  output rename_pkg::ptag_t     [rename_pkg::LANES-1:0] rdc_out,

  // write ports
  input  rename_pkg::arch_idx_t [rename_pkg::LANES-1:0] wr_idx,
  input  rename_pkg::ptag_t     [rename_pkg::LANES-1:0] wr_data,
  input  logic                  [rename_pkg::LANES-1:0] wr_en,

  // bulk copy and snapshot
  input  logic                                          copy,         // load whole table
  input  rename_pkg::map_snapshot_t                     reg_vals_in,
  output rename_pkg::map_snapshot_t                     reg_vals_out  // forwarded view
);

  localparam int REG_SZ = 1 << IDX_WIDTH;                 // entries in the table

  logic [DATA_WIDTH-1:0] registers [REG_SZ];              // one tag per arch reg

  //////////////////////////////
  // read ports
  //////////////////////////////

  // no write forwarding here, reads see stored state only
  for (genvar l = 0; l < rename_pkg::LANES; l++) begin : g_rd
    assign rda_out[l] = (rda_idx[l] == ZERO_REGISTER) ? ZERO_REG_VAL  // zero reg pinned
                                                      : registers[rda_idx[l]];
    assign rdb_out[l] = (rdb_idx[l] == ZERO_REGISTER) ? ZERO_REG_VAL
                                                      : registers[rdb_idx[l]];
    assign rdc_out[l] = (rdc_idx[l] == ZERO_REGISTER) ? ZERO_REG_VAL  // old dest lookup
                                                      : registers[rdc_idx[l]];
  end

  //////////////////////////////
  // forwarded snapshot
  //////////////////////////////

  // shows this cycle's writes already; the speculative map copies from this
  // on recovery, so a retirement in the same cycle is not lost
  for (genvar i = 0; i < REG_SZ; i++) begin : g_snap
    assign reg_vals_out[i] =
        (i == ZERO_REGISTER)                ? ZERO_REG_VAL :  // always the zero tag
        (wr_en[1] && (wr_idx[1] == i))      ? wr_data[1]   :  // lane 1 is younger
        (wr_en[0] && (wr_idx[0] == i))      ? wr_data[0]   :
                                              registers[i];
  end

  //////////////////////////////
  // table update
  //////////////////////////////

  always_ff @(posedge wr_clk) begin
    for (int i = 0; i < REG_SZ; i++) begin
      if (i == ZERO_REGISTER) begin
        registers[i] <= ZERO_REG_VAL;                     // never remapped
      end else if (reset) begin
        registers[i] <= DATA_WIDTH'(i);                   // identity map
      end else if (copy) begin
        registers[i] <= reg_vals_in[i];                   // recovery, whole table
      end else if (wr_en[1] && (wr_idx[1] == i)) begin
        registers[i] <= wr_data[1];                       // lane 1 wins a tie
      end else if (wr_en[0] && (wr_idx[0] == i)) begin
        registers[i] <= wr_data[0];
      end
    end
  end

endmodule

// ==== rename_assertions.sv ====
`timescale 1ns/1ps

module rename_assertions (
  input logic                                            wr_clk,
  input logic                                            reset,
  input rename_pkg::rename_req_t [rename_pkg::LANES-1:0] req,
  input rename_pkg::retire_t     [rename_pkg::LANES-1:0] ret,
  input logic                                            recover,
  input rename_pkg::rename_rsp_t [rename_pkg::LANES-1:0] rsp,
  input rename_pkg::map_snapshot_t                       arch_map
);

  rename_pkg::map_snapshot_t arch_map_q;                  // committed map one cycle back
  int                        error_count = 0;             // assertion failures so far

  always_ff @(posedge wr_clk) begin
    arch_map_q <= arch_map;
  end

  for (genvar l = 0; l < rename_pkg::LANES; l++) begin : g_lane
    a_no_zero_dest: assert property (@(posedge wr_clk) disable iff (reset)
      (req[l].valid && req[l].dest_valid) |-> (req[l].dest != rename_pkg::ZERO_REG))
      else begin
        error_count++;
        $error("lane %0d renames the zero register", l);
      end
    a_no_zero_retire: assert property (@(posedge wr_clk) disable iff (reset)
      ret[l].valid |-> (ret[l].dest != rename_pkg::ZERO_REG))
      else begin
        error_count++;
        $error("lane %0d retires into the zero register", l);
      end
  end

  a_zero_tag_pinned: assert property (@(posedge wr_clk)
    arch_map[rename_pkg::ZERO_REG] == rename_pkg::ZERO_TAG)
    else begin
      error_count++;
      $error("arch_map zero entry lost its fixed tag");
    end

  // lane 0 has no bypass and its lookups show the restored table
  a_recover_restores: assert property (@(posedge wr_clk) disable iff (reset)
    recover |=> (rsp[0].tag_a == arch_map_q[req[0].src_a]) &&
                (rsp[0].tag_b == arch_map_q[req[0].src_b]) &&
                (rsp[0].old_tag == arch_map_q[req[0].dest]))
    else begin
      error_count++;
      $error("speculative map differs from committed map after recovery");
    end

endmodule

bind rename_top rename_assertions i_rename_assertions (
  .wr_clk   (wr_clk),
  .reset    (reset),
  .req      (req),
  .ret      (ret),
  .recover  (recover),
  .rsp      (rsp),
  .arch_map (arch_map)
);

// ==== rename_pkg.sv ====
package rename_pkg;

  ////////////////////////////////
  // widths
  ////////////////////////////////

  localparam int ARCH_IDX_WIDTH = 5;                      // 32 architectural regs
  localparam int TAG_WIDTH      = 6;                      // 64 physical regs
  localparam int LANES          = 2;                      // rename width, two-wide core
  localparam int NUM_ARCH_REGS  = 1 << ARCH_IDX_WIDTH;    // map table depth

  typedef logic [ARCH_IDX_WIDTH-1:0] arch_idx_t;          // architectural index
  typedef logic [TAG_WIDTH-1:0]      ptag_t;              // physical tag

  ////////////////////////////////
  // zero register
  ////////////////////////////////

  localparam arch_idx_t ZERO_REG = arch_idx_t'(31);       // hardwired zero, arch side
  localparam ptag_t     ZERO_TAG = ptag_t'(31);           // its fixed physical tag

  ////////////////////////////////
  // per-lane bundles
  ////////////////////////////////

  typedef struct packed {
    logic      valid;       // lane carries an instruction
    arch_idx_t src_a;       // first source
    arch_idx_t src_b;       // second source
    logic      dest_valid;  // instruction writes a register
    arch_idx_t dest;        // destination
    ptag_t     new_tag;     // tag handed out by the free list
  } rename_req_t;

  typedef struct packed {
    ptag_t tag_a;           // current mapping of src_a
    ptag_t tag_b;           // current mapping of src_b
    ptag_t old_tag;         // previous mapping of dest, freed at retire
  } rename_rsp_t;

  typedef struct packed {
    logic      valid;       // retiring instruction writes a register
    arch_idx_t dest;        // committed destination
    ptag_t     tag;         // committed tag
  } retire_t;

  // whole map, entry i holds the tag of arch reg i
  typedef ptag_t [NUM_ARCH_REGS-1:0] map_snapshot_t;

endpackage

// ==== rename_top.sv ====
`timescale 1ns/1ps

module rename_top #(
  parameter int IDX_WIDTH = rename_pkg::ARCH_IDX_WIDTH,
  parameter int DATA_WIDTH = rename_pkg::TAG_WIDTH,
  parameter logic [IDX_WIDTH-1:0] ZERO_REGISTER = rename_pkg::ZERO_REG,
  parameter logic [DATA_WIDTH-1:0] ZERO_REG_VAL = rename_pkg::ZERO_TAG
) (
  input  logic                                            wr_clk,
  input  logic                                            reset,
  input  rename_pkg::rename_req_t [rename_pkg::LANES-1:0] req,      // rename bundle
  input  rename_pkg::retire_t     [rename_pkg::LANES-1:0] ret,      // retiring bundle
  input  logic                                            recover,  // mispredict pulse
  output rename_pkg::rename_rsp_t [rename_pkg::LANES-1:0] rsp,
  output rename_pkg::map_snapshot_t                       arch_map  // committed map
);

  //////////////////////////////
  // lane unpacking
  //////////////////////////////

  rename_pkg::arch_idx_t [rename_pkg::LANES-1:0] spec_src_a;  // read port A
  rename_pkg::arch_idx_t [rename_pkg::LANES-1:0] spec_src_b;  // read port B
  rename_pkg::arch_idx_t [rename_pkg::LANES-1:0] spec_dest;   // read port C and write idx
  rename_pkg::ptag_t     [rename_pkg::LANES-1:0] spec_new_tag;
  logic                  [rename_pkg::LANES-1:0] spec_wr_en;
  rename_pkg::ptag_t     [rename_pkg::LANES-1:0] map_a;       // raw lookups
  rename_pkg::ptag_t     [rename_pkg::LANES-1:0] map_b;
  rename_pkg::ptag_t     [rename_pkg::LANES-1:0] map_c;

  rename_pkg::arch_idx_t [rename_pkg::LANES-1:0] ret_dest;
  rename_pkg::ptag_t     [rename_pkg::LANES-1:0] ret_tag;
  logic                  [rename_pkg::LANES-1:0] ret_wr_en;

  for (genvar l = 0; l < rename_pkg::LANES; l++) begin : g_lane
    assign spec_src_a[l]   = req[l].src_a;
    assign spec_src_b[l]   = req[l].src_b;
    assign spec_dest[l]    = req[l].dest;
    assign spec_new_tag[l] = req[l].new_tag;
    assign spec_wr_en[l]   = req[l].valid && req[l].dest_valid;  // no back-pressure
    assign ret_dest[l]     = ret[l].dest;
    assign ret_tag[l]      = ret[l].tag;
    assign ret_wr_en[l]    = ret[l].valid;
  end

  //////////////////////////////
  // speculative map
  //////////////////////////////

  regfile #(
    .IDX_WIDTH     (IDX_WIDTH),
    .DATA_WIDTH    (DATA_WIDTH),
    .ZERO_REGISTER (ZERO_REGISTER),
    .ZERO_REG_VAL  (ZERO_REG_VAL)
  ) i_spec_map (
    .wr_clk       (wr_clk),
    .reset        (reset),
    .rda_idx      (spec_src_a),
    .rdb_idx      (spec_src_b),
    .rdc_idx      (spec_dest),      // old mapping of dest
    .rda_out      (map_a),
    .rdb_out      (map_b),
    .rdc_out      (map_c),
    .wr_idx       (spec_dest),
    .wr_data      (spec_new_tag),
    .wr_en        (spec_wr_en),
    .copy         (recover),        // restore from committed map
    .reg_vals_in  (arch_map),       // forwarded, includes this cycle's retires
    .reg_vals_out ()                // not needed on the speculative side
  );

  //////////////////////////////
  // retirement map
  //////////////////////////////

  regfile #(
    .IDX_WIDTH     (IDX_WIDTH),
    .DATA_WIDTH    (DATA_WIDTH),
    .ZERO_REGISTER (ZERO_REGISTER),
    .ZERO_REG_VAL  (ZERO_REG_VAL)
  ) i_retire_map (
    .wr_clk       (wr_clk),
    .reset        (reset),
    .rda_idx      ('0),             // reads unused
    .rdb_idx      ('0),
    .rdc_idx      ('0),
    .rda_out      (),
    .rdb_out      (),
    .rdc_out      (),
    .wr_idx       (ret_dest),
    .wr_data      (ret_tag),
    .wr_en        (ret_wr_en),
    .copy         (1'b0),           // committed state is never rolled back
    .reg_vals_in  ('0),
    .reg_vals_out (arch_map)
  );

  //////////////////////////////
  // intra-bundle bypass
  //////////////////////////////

  bundle_dep_check i_dep_check (
    .req   (req),
    .map_a (map_a),
    .map_b (map_b),
    .map_c (map_c),
    .rsp   (rsp)
  );

endmodule

// ==== tb_rename.sv ====
`timescale 1ns/1ps

module tb_rename;

  localparam int EDGE_POLLS = 120;                        // 1 ns polls allowed per clock phase
  localparam int NREGS      = rename_pkg::NUM_ARCH_REGS;

  logic                                            wr_clk;
  logic                                            reset;
  logic                                            recover;
  rename_pkg::rename_req_t [rename_pkg::LANES-1:0] req;
  rename_pkg::retire_t     [rename_pkg::LANES-1:0] ret;
  rename_pkg::rename_rsp_t [rename_pkg::LANES-1:0] rsp;
  rename_pkg::map_snapshot_t                       arch_map;

  rename_pkg::ptag_t spec_model [NREGS];                  // reference speculative map
  rename_pkg::ptag_t arch_model [NREGS];                  // reference retirement map
  integer            seed = 32'hbb8e;

  rename_top i_dut (
    .wr_clk   (wr_clk),
    .reset    (reset),
    .req      (req),
    .ret      (ret),
    .recover  (recover),
    .rsp      (rsp),
    .arch_map (arch_map)
  );

  initial begin
    wr_clk = 1'b0;
    forever #50 wr_clk = ~wr_clk;                         // 100 ns period
  end

  //////////////////////////////
  // reporting and waiting
  //////////////////////////////

  task automatic abort_run(input string what);
    if (what != "") $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic wait_level(input logic level);
    int polls;
    polls = 0;
    while (wr_clk !== level) begin                        // polls sit 0.5 ns off the edges
      #1;
      polls++;
      if (polls > EDGE_POLLS) abort_run("timeout, wr_clk stopped toggling");
    end
  endtask

  task automatic wait_fall;
    wait_level(1'b1);
    wait_level(1'b0);
  endtask

  task automatic check_rsp(input string name, input rename_pkg::rename_rsp_t exp,
                           input rename_pkg::rename_rsp_t act);
    if (act !== exp) begin
      $display("Error: time %0t %s expected a=%0d b=%0d old=%0d got a=%0d b=%0d old=%0d",
               $time, name, exp.tag_a, exp.tag_b, exp.old_tag, act.tag_a, act.tag_b,
               act.old_tag);
      abort_run("");
    end
  endtask

  task automatic check_snapshot(input string name, input rename_pkg::map_snapshot_t exp,
                                input rename_pkg::map_snapshot_t act);
    for (int i = 0; i < NREGS; i++) begin
      if (act[i] !== exp[i]) begin
        $display("Error: time %0t %s[%0d] expected %0d got %0d", $time, name, i,
                 exp[i], act[i]);
        abort_run("");
      end
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic rename_pkg::ptag_t spec_lookup(input rename_pkg::arch_idx_t idx);
    if (idx == rename_pkg::ZERO_REG) return rename_pkg::ZERO_TAG;  // pinned
    return spec_model[idx];
  endfunction

  // lane 1 sees lane 0's rename in the same bundle
  function automatic rename_pkg::ptag_t lane1_view(input rename_pkg::arch_idx_t idx);
    if (idx == rename_pkg::ZERO_REG) return rename_pkg::ZERO_TAG;
    if (req[0].valid && req[0].dest_valid && idx == req[0].dest) return req[0].new_tag;
    return spec_model[idx];
  endfunction

  function automatic rename_pkg::map_snapshot_t forwarded_arch;
    rename_pkg::map_snapshot_t snap;
    for (int i = 0; i < NREGS; i++) snap[i] = arch_model[i];
    for (int l = 0; l < rename_pkg::LANES; l++) begin
      if (ret[l].valid) snap[ret[l].dest] = ret[l].tag;  // lane 1 applied last and wins
    end
    snap[rename_pkg::ZERO_REG] = rename_pkg::ZERO_TAG;
    return snap;
  endfunction

  function automatic rename_pkg::rename_req_t make_req(input bit v, input int sa, input int sb,
                                                        input bit dv, input int d, input int t);
    rename_pkg::rename_req_t r;
    r.valid      = v;
    r.src_a      = rename_pkg::arch_idx_t'(sa);
    r.src_b      = rename_pkg::arch_idx_t'(sb);
    r.dest_valid = dv;
    r.dest       = rename_pkg::arch_idx_t'(d);
    r.new_tag    = rename_pkg::ptag_t'(t);
    return r;
  endfunction

  function automatic rename_pkg::rename_req_t random_req;
    int d;
    d = $unsigned($random(seed)) % 31;                    // dest never the zero reg
    return make_req($random(seed), $random(seed), $random(seed), $random(seed), d,
                    $random(seed));
  endfunction

  function automatic rename_pkg::retire_t random_ret;
    rename_pkg::retire_t t;
    t.valid = $random(seed);
    t.dest  = rename_pkg::arch_idx_t'($unsigned($random(seed)) % 31);
    t.tag   = rename_pkg::ptag_t'($random(seed));
    return t;
  endfunction

  //////////////////////////////
  // one clock cycle
  //////////////////////////////

  // starts just after a falling edge and returns after the next one
  task automatic run_cycle(input rename_pkg::rename_req_t r0, input rename_pkg::rename_req_t r1,
                           input rename_pkg::retire_t t0, input rename_pkg::retire_t t1,
                           input logic rec);
    rename_pkg::rename_rsp_t   exp_rsp;
    rename_pkg::map_snapshot_t exp_snap;
    req[0]  = r0;
    req[1]  = r1;
    ret[0]  = t0;
    ret[1]  = t1;
    recover = rec;
    #10;                                                  // let comb paths settle
    exp_rsp = '{spec_lookup(r0.src_a), spec_lookup(r0.src_b), spec_lookup(r0.dest)};
    check_rsp("rsp[0]", exp_rsp, rsp[0]);
    exp_rsp = '{lane1_view(r1.src_a), lane1_view(r1.src_b), lane1_view(r1.dest)};
    check_rsp("rsp[1]", exp_rsp, rsp[1]);
    exp_snap = forwarded_arch();
    check_snapshot("arch_map", exp_snap, arch_map);
    for (int i = 0; i < NREGS; i++) begin                 // predict the rising edge
      if (rec) spec_model[i] = exp_snap[i];               // copy beats renames
      arch_model[i] = exp_snap[i];
    end
    for (int l = 0; l < rename_pkg::LANES; l++) begin
      if (!rec && req[l].valid && req[l].dest_valid) spec_model[req[l].dest] = req[l].new_tag;
    end
    wait_fall();
    if (i_dut.i_rename_assertions.error_count != 0) begin
      abort_run("a bound assertion on rename_top failed");
    end
  endtask

  task automatic rename_all_indices;
    for (int i = 0; i < NREGS; i += 4) begin              // old tag read through dest too
      run_cycle(make_req(1, i, i + 1, 0, i, 0), make_req(1, i + 2, i + 3, 0, i + 2, 0),
                '0, '0, 1'b0);
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_reset_identity;
    rename_pkg::map_snapshot_t ident;
    for (int i = 0; i < NREGS; i++) ident[i] = rename_pkg::ptag_t'(i);
    check_snapshot("arch_map", ident, arch_map);
    rename_all_indices();
  endtask

  task automatic test_rename_writes;
    run_cycle(make_req(1, 1, 2, 1, 3, 40), make_req(1, 4, 5, 1, 7, 41), '0, '0, 1'b0);
    run_cycle(make_req(1, 3, 7, 1, 3, 42), make_req(0, 0, 0, 0, 0, 0), '0, '0, 1'b0);
    run_cycle(make_req(1, 0, 0, 1, 5, 50), make_req(1, 0, 0, 1, 5, 51), '0, '0, 1'b0);
    run_cycle(make_req(1, 5, 5, 0, 5, 0), make_req(1, 3, 7, 0, 5, 0), '0, '0, 1'b0);
  endtask

  task automatic test_bundle_bypass;
    run_cycle(make_req(1, 1, 1, 1, 9, 60), make_req(1, 9, 9, 1, 9, 61), '0, '0, 1'b0);
    run_cycle(make_req(1, 1, 1, 0, 9, 62), make_req(1, 9, 9, 1, 10, 63), '0, '0, 1'b0);
    run_cycle(make_req(0, 1, 1, 1, 10, 62), make_req(1, 10, 10, 1, 11, 0), '0, '0, 1'b0);
  endtask

  task automatic test_zero_reg;
    repeat (20) run_cycle(random_req(), random_req(), random_ret(), random_ret(), 1'b0);
    run_cycle(make_req(1, 31, 31, 0, 31, 0), make_req(1, 31, 31, 0, 31, 0), '0, '0, 1'b0);
  endtask

  task automatic test_retire_recover;
    run_cycle(make_req(1, 0, 0, 1, 4, 20), make_req(1, 0, 0, 1, 6, 21), '0, '0, 1'b0);
    run_cycle(make_req(0, 0, 0, 0, 0, 0), make_req(0, 0, 0, 0, 0, 0), '{1'b1, 5'd6, 6'd44},
              '0, 1'b0);
    run_cycle(make_req(1, 0, 0, 1, 8, 22), make_req(0, 0, 0, 0, 0, 0), '{1'b1, 5'd4, 6'd45},
              '{1'b1, 5'd4, 6'd46}, 1'b1);              // retire and recover together
    rename_all_indices();
  endtask

  task automatic test_random_mix;
    rename_pkg::rename_req_t r0;
    rename_pkg::rename_req_t r1;
    logic                    rec;
    repeat (300) begin
      r0  = random_req();
      r1  = random_req();
      rec = ($random(seed) & 15) == 0;                    // roughly one in 16
      run_cycle(r0, r1, random_ret(), random_ret(), rec);
    end
  endtask

  initial begin
    reset   = 1'b1;
    recover = 1'b0;
    req     = '0;
    ret     = '0;
    #0.5;                                                 // off the clock grid
    wait_fall();
    wait_fall();                                          // two reset cycles
    for (int i = 0; i < NREGS; i++) begin
      spec_model[i] = rename_pkg::ptag_t'(i);
      arch_model[i] = rename_pkg::ptag_t'(i);
    end
    reset = 1'b0;
    test_reset_identity();
    test_rename_writes();
    test_bundle_bypass();
    test_zero_reg();
    test_retire_recover();
    test_random_mix();
    if (i_dut.i_rename_assertions.error_count != 0) begin
      abort_run("a bound assertion on rename_top failed");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule
